// ==== logic/gat_pkg.sv ====
/*
  Shared sizes, widths, memory layout and payload types for the
  first GAT attention layer. Modules import this package inside their
  body and use scoped names in their headers.
*/
`default_nettype none

package gat_pkg;

  // ==========================================================
  // Sizes
  // ==========================================================
  localparam int TOTAL_NODES       = 12;
  localparam int NUM_FEATURE_IN    = 8;
  localparam int NUM_FEATURE_OUT   = 4;
  localparam int H_NUM_SPARSE_DATA = 64;
  localparam int DATA_WIDTH        = 8;
  localparam int LEAKY_SHIFT       = 3;

  // ==========================================================
  // Derived widths
  // ==========================================================
  localparam int COL_IDX_WIDTH    = $clog2(NUM_FEATURE_IN);
  // Row length may equal NUM_FEATURE_IN
  localparam int ROW_LEN_WIDTH    = $clog2(NUM_FEATURE_IN + 1);
  localparam int WH_DATA_WIDTH    = 2 * DATA_WIDTH + $clog2(NUM_FEATURE_IN);
  localparam int COEF_WIDTH       = 32;

  // Weight rows, then a_src and a_nbr
  localparam int WEIGHT_DEPTH     = NUM_FEATURE_IN + 2;
  localparam int A_SRC_ROW        = NUM_FEATURE_IN;
  localparam int A_NBR_ROW        = NUM_FEATURE_IN + 1;

  localparam int H_DATA_ADDR_W    = $clog2(H_NUM_SPARSE_DATA);
  localparam int NODE_INFO_ADDR_W = $clog2(TOTAL_NODES);
  localparam int WEIGHT_ADDR_W    = $clog2(WEIGHT_DEPTH);
  localparam int FEAT_ADDR_W      = $clog2(TOTAL_NODES);

  // ==========================================================
  // Payload types
  // ==========================================================
  typedef logic signed [DATA_WIDTH-1:0]    data_t;
  typedef logic signed [WH_DATA_WIDTH-1:0] wh_t;
  typedef logic signed [COEF_WIDTH-1:0]    coef_t;

  typedef struct packed {
    data_t                    value;
    logic [COL_IDX_WIDTH-1:0] col;
  } h_entry_t;

  typedef struct packed {
    logic [ROW_LEN_WIDTH-1:0] row_len;
    logic                     first;
  } node_info_t;

  typedef data_t [NUM_FEATURE_OUT-1:0] wgt_row_t;
  typedef wh_t   [NUM_FEATURE_OUT-1:0] wh_row_t;

endpackage

`default_nettype wire

// ==== logic/gat_wh_if.sv ====
/*
  WH row link from the SpMM stage to the DMVM stage.
  valid is a one-cycle strobe per node; a_ready flows back as a level
  once the attention vectors are loaded.
*/
`default_nettype none

interface gat_wh_if;
  import gat_pkg::*;

  logic    valid;
  wh_row_t wh;
  logic    first;
  logic    a_ready;

  modport producer (output valid, output wh, output first, input a_ready);

  modport consumer (input valid, input wh, input first, output a_ready);

endinterface

`default_nettype wire

// ==== logic/gat_bram.sv ====
/*
  Block memory with one write port and two registered read ports.
  The payload type and depth are set per instance; read data appears
  one cycle after the address.
*/
`default_nettype none

module gat_bram #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 16,
  localparam int ADDR_W    = $clog2(DEPTH)
) (
  input  logic              clk,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  payload_t          wr_data,
  input  logic [ADDR_W-1:0] rd_addr_b,
  output payload_t          rd_data_b,
  input  logic [ADDR_W-1:0] rd_addr_c,
  output payload_t          rd_data_c
);

  payload_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data_b <= mem[rd_addr_b];
    rd_data_c <= mem[rd_addr_c];
  end

  a_wr_in_range: assert property (@(posedge clk) wr_en |-> (wr_addr < DEPTH));

endmodule

`default_nettype wire

// ==== logic/spmm_stage.sv ====
/*
  Sparse row times weight matrix. Walks the nodes in order, streams
  each row's nonzeros from a running H pointer and accumulates value
  times weight row in parallel MACs. One WH row per node leaves on the
  producer side of the WH link, row length plus 3 cycles per node.
*/
`default_nettype none

module spmm_stage #(
  parameter int TOTAL_NODES    = 12,
  parameter int NUM_FEATURE_IN = 8
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 h_data_load_done,
  input  logic                                 node_info_load_done,
  input  logic                                 wgt_load_done,
  output logic [gat_pkg::H_DATA_ADDR_W-1:0]    h_addr,
  input  gat_pkg::h_entry_t                    h_data,
  output logic [gat_pkg::NODE_INFO_ADDR_W-1:0] info_addr,
  input  gat_pkg::node_info_t                  info_data,
  output logic [gat_pkg::WEIGHT_ADDR_W-1:0]    wgt_addr,
  input  gat_pkg::wgt_row_t                    wgt_data,
  gat_wh_if.producer                           wh
);
  import gat_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_INFO, S_ROW, S_DRAIN, S_DONE} state_t;

  state_t                      state;
  logic [NODE_INFO_ADDR_W-1:0] node_idx;
  logic [H_DATA_ADDR_W-1:0]    h_ptr;
  logic [ROW_LEN_WIDTH-1:0]    row_cnt;
  logic                        drain_cnt;
  logic                        first_r;
  logic                        last_r;
  logic                        issue_d1;
  logic                        issue_d2;
  logic                        start;
  data_t                       val_d;
  wh_row_t                     acc;
  wh_row_t                     prod;
  wh_row_t                     sum_next;

  assign start     = h_data_load_done && node_info_load_done && wgt_load_done && wh.a_ready;
  assign info_addr = node_idx;
  assign h_addr    = h_ptr;
  // Column index picks the weight row
  assign wgt_addr  = WEIGHT_ADDR_W'(h_data.col);

  // ==========================================================
  // Node controller
  // ==========================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= S_IDLE;
      node_idx  <= '0;
      h_ptr     <= '0;
      row_cnt   <= '0;
      drain_cnt <= 1'b0;
      wh.valid  <= 1'b0;
    end else begin
      wh.valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_INFO;
          end
        end
        S_INFO: begin
          node_idx  <= node_idx + 1'b1;
          row_cnt   <= info_data.row_len;
          drain_cnt <= 1'b0;
          state     <= (info_data.row_len == '0) ? S_DRAIN : S_ROW;
        end
        S_ROW: begin
          h_ptr   <= h_ptr + 1'b1;
          row_cnt <= row_cnt - 1'b1;
          if (row_cnt == ROW_LEN_WIDTH'(1)) begin
            state <= S_DRAIN;
          end
        end
        S_DRAIN: begin
          drain_cnt <= 1'b1;
          if (drain_cnt) begin
            wh.valid <= 1'b1;
            state    <= last_r ? S_DONE : S_INFO;
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_INFO) begin
      first_r <= info_data.first;
      last_r  <= (node_idx == NODE_INFO_ADDR_W'(TOTAL_NODES - 1));
    end
  end

  // H read, then weight read, then MAC
  always_ff @(posedge clk) begin
    if (rst) begin
      issue_d1 <= 1'b0;
      issue_d2 <= 1'b0;
    end else begin
      issue_d1 <= (state == S_ROW);
      issue_d2 <= issue_d1;
    end
  end

  // ==========================================================
  // Multiply-accumulate lanes
  // ==========================================================
  always_comb begin
    for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
      prod[i]     = val_d * wgt_data[i];
      sum_next[i] = acc[i] + (issue_d2 ? prod[i] : wh_t'(0));
    end
  end

  always_ff @(posedge clk) begin
    val_d <= h_data.value;
    if (state == S_INFO) begin
      acc <= '0;
    end else if (issue_d2) begin
      acc <= sum_next;
    end
    if (state == S_DRAIN && drain_cnt) begin
      wh.wh    <= sum_next;
      wh.first <= first_r;
    end
  end

  a_col_in_range: assert property (@(posedge clk) disable iff (rst)
    issue_d1 |-> (h_data.col < NUM_FEATURE_IN));

endmodule

`default_nettype wire

// ==== logic/dmvm_stage.sv ====
/*
  Attention score per node. Loads a_src and a_nbr once the weights are
  in, then runs a 3-stage pipeline: element products, the two dot
  product sums with the target hold, and target plus neighbour sum
  through a leaky ReLU.
*/
`default_nettype none

module dmvm_stage #(
  parameter int LEAKY_SHIFT = 3
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              wgt_load_done,
  output logic [gat_pkg::WEIGHT_ADDR_W-1:0] wgt_addr,
  input  gat_pkg::wgt_row_t                 wgt_data,
  gat_wh_if.consumer                        wh,
  output logic                              coef_valid,
  output gat_pkg::coef_t                    coef
);
  import gat_pkg::*;

  logic [1:0] fetch_cnt;
  wgt_row_t   a_src;
  wgt_row_t   a_nbr;
  coef_t      p_src [NUM_FEATURE_OUT];
  coef_t      p_nbr [NUM_FEATURE_OUT];
  logic       v1;
  logic       f1;
  logic       v2;
  logic       seen_valid;
  coef_t      sum_src;
  coef_t      sum_nbr;
  coef_t      nbr_s2;
  coef_t      tgt_src;
  coef_t      raw;

  // ==========================================================
  // Attention vector fetch
  // ==========================================================
  assign wgt_addr   = (fetch_cnt == 2'd0) ? WEIGHT_ADDR_W'(A_SRC_ROW) : WEIGHT_ADDR_W'(A_NBR_ROW);
  assign wh.a_ready = (fetch_cnt == 2'd3);

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_cnt <= 2'd0;
    end else if (fetch_cnt != 2'd3 && (fetch_cnt != 2'd0 || wgt_load_done)) begin
      fetch_cnt <= fetch_cnt + 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_cnt == 2'd1) begin
      a_src <= wgt_data;
    end
    if (fetch_cnt == 2'd2) begin
      a_nbr <= wgt_data;
    end
  end

  // ==========================================================
  // Score pipeline
  // ==========================================================
  always_comb begin
    sum_src = '0;
    sum_nbr = '0;
    for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
      sum_src = sum_src + p_src[i];
      sum_nbr = sum_nbr + p_nbr[i];
    end
  end

  assign raw = tgt_src + nbr_s2;

  always_ff @(posedge clk) begin
    if (rst) begin
      v1         <= 1'b0;
      v2         <= 1'b0;
      coef_valid <= 1'b0;
    end else begin
      v1         <= wh.valid;
      v2         <= v1;
      coef_valid <= v2;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
      p_src[i] <= a_src[i] * wh.wh[i];
      p_nbr[i] <= a_nbr[i] * wh.wh[i];
    end
    f1     <= wh.first;
    nbr_s2 <= sum_nbr;
    // Target of a new subgraph
    if (v1 && f1) begin
      tgt_src <= sum_src;
    end
    coef <= raw[COEF_WIDTH-1] ? (raw >>> LEAKY_SHIFT) : raw;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      seen_valid <= 1'b0;
    end else if (wh.valid) begin
      seen_valid <= 1'b1;
    end
  end

  a_first_is_target: assert property (@(posedge clk) disable iff (rst)
    (wh.valid && !seen_valid) |-> wh.first);

endmodule

`default_nettype wire

// ==== logic/coef_store.sv ====
/*
  Result memory for the attention scores. Scores are written in node
  order on the cycle after coef_valid; the host reads them back one
  cycle after feat_bram_addrb. gat_ready rises after the last write.
*/
`default_nettype none

module coef_store #(
  parameter int TOTAL_NODES = 12
) (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            coef_valid,
  input  gat_pkg::coef_t                  coef,
  input  logic [gat_pkg::FEAT_ADDR_W-1:0] feat_bram_addrb,
  output gat_pkg::coef_t                  feat_bram_dout,
  output logic                            gat_ready
);
  import gat_pkg::*;

  coef_t                  mem [TOTAL_NODES];
  logic                   wr_en;
  coef_t                  wr_data;
  logic [FEAT_ADDR_W-1:0] wr_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_en     <= 1'b0;
      wr_cnt    <= '0;
      gat_ready <= 1'b0;
    end else begin
      wr_en <= coef_valid;
      if (wr_en) begin
        wr_cnt <= wr_cnt + 1'b1;
        if (wr_cnt == FEAT_ADDR_W'(TOTAL_NODES - 1)) begin
          gat_ready <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    wr_data <= coef;
    if (wr_en) begin
      mem[wr_cnt] <= wr_data;
    end
    feat_bram_dout <= mem[feat_bram_addrb];
  end

  a_no_late_coef: assert property (@(posedge clk) disable iff (rst) gat_ready |-> !coef_valid);

endmodule

`default_nettype wire

// ==== logic/gat_top.sv ====
/*
  Top level of the first GAT attention layer. The host loads the H
  data, node info and weight memories, raises the load-done levels,
  waits for gat_ready and reads one score per node back through
  feat_bram_addrb and feat_bram_dout.
*/
`default_nettype none

module gat_top #(
  parameter int H_NUM_SPARSE_DATA = gat_pkg::H_NUM_SPARSE_DATA,
  parameter int TOTAL_NODES       = gat_pkg::TOTAL_NODES,
  parameter int NUM_FEATURE_IN    = gat_pkg::NUM_FEATURE_IN,
  parameter int LEAKY_SHIFT       = gat_pkg::LEAKY_SHIFT
) (
  input  logic                                    clk,
  input  logic                                    rst,

  input  logic                                    h_data_bram_load_done,
  input  logic                                    h_node_info_bram_load_done,
  input  logic                                    wgt_bram_load_done,

  input  logic                                    h_data_bram_ena,
  input  logic                                    h_data_bram_wea,
  input  logic [gat_pkg::H_DATA_ADDR_W-1:0]       h_data_bram_addra,
  input  logic [$bits(gat_pkg::h_entry_t)-1:0]    h_data_bram_din,

  input  logic                                    h_node_info_bram_ena,
  input  logic                                    h_node_info_bram_wea,
  input  logic [gat_pkg::NODE_INFO_ADDR_W-1:0]    h_node_info_bram_addra,
  input  logic [$bits(gat_pkg::node_info_t)-1:0]  h_node_info_bram_din,

  input  logic                                    wgt_bram_ena,
  input  logic                                    wgt_bram_wea,
  input  logic [gat_pkg::WEIGHT_ADDR_W-1:0]       wgt_bram_addra,
  input  logic [$bits(gat_pkg::wgt_row_t)-1:0]    wgt_bram_din,

  input  logic [gat_pkg::FEAT_ADDR_W-1:0]         feat_bram_addrb,
  output logic signed [gat_pkg::COEF_WIDTH-1:0]   feat_bram_dout,
  output logic                                    gat_ready
);
  import gat_pkg::*;

  logic [H_DATA_ADDR_W-1:0]    h_addr;
  h_entry_t                    h_data;
  logic [NODE_INFO_ADDR_W-1:0] info_addr;
  node_info_t                  info_data;
  logic [WEIGHT_ADDR_W-1:0]    spmm_wgt_addr;
  wgt_row_t                    spmm_wgt_data;
  logic [WEIGHT_ADDR_W-1:0]    dmvm_wgt_addr;
  wgt_row_t                    dmvm_wgt_data;
  logic                        coef_valid;
  coef_t                       coef;

  gat_wh_if wh_link ();

  // ==========================================================
  // Host-loaded memories
  // ==========================================================
  gat_bram #(.payload_t(h_entry_t), .DEPTH(H_NUM_SPARSE_DATA)) u_h_data_bram (
    .clk       (clk),
    .wr_en     (h_data_bram_ena && h_data_bram_wea),
    .wr_addr   (h_data_bram_addra),
    .wr_data   (h_entry_t'(h_data_bram_din)),
    .rd_addr_b (h_addr),
    .rd_data_b (h_data),
    .rd_addr_c ('0),
    .rd_data_c ()
  );

  gat_bram #(.payload_t(node_info_t), .DEPTH(TOTAL_NODES)) u_node_info_bram (
    .clk       (clk),
    .wr_en     (h_node_info_bram_ena && h_node_info_bram_wea),
    .wr_addr   (h_node_info_bram_addra),
    .wr_data   (node_info_t'(h_node_info_bram_din)),
    .rd_addr_b (info_addr),
    .rd_data_b (info_data),
    .rd_addr_c ('0),
    .rd_data_c ()
  );

  // Port b feeds the MACs, port c the attention vectors
  gat_bram #(.payload_t(wgt_row_t), .DEPTH(WEIGHT_DEPTH)) u_wgt_bram (
    .clk       (clk),
    .wr_en     (wgt_bram_ena && wgt_bram_wea),
    .wr_addr   (wgt_bram_addra),
    .wr_data   (wgt_row_t'(wgt_bram_din)),
    .rd_addr_b (spmm_wgt_addr),
    .rd_data_b (spmm_wgt_data),
    .rd_addr_c (dmvm_wgt_addr),
    .rd_data_c (dmvm_wgt_data)
  );

  // ==========================================================
  // Pipeline
  // ==========================================================
  spmm_stage #(.TOTAL_NODES(TOTAL_NODES), .NUM_FEATURE_IN(NUM_FEATURE_IN)) u_spmm (
    .clk                 (clk),
    .rst                 (rst),
    .h_data_load_done    (h_data_bram_load_done),
    .node_info_load_done (h_node_info_bram_load_done),
    .wgt_load_done       (wgt_bram_load_done),
    .h_addr              (h_addr),
    .h_data              (h_data),
    .info_addr           (info_addr),
    .info_data           (info_data),
    .wgt_addr            (spmm_wgt_addr),
    .wgt_data            (spmm_wgt_data),
    .wh                  (wh_link.producer)
  );

  dmvm_stage #(.LEAKY_SHIFT(LEAKY_SHIFT)) u_dmvm (
    .clk           (clk),
    .rst           (rst),
    .wgt_load_done (wgt_bram_load_done),
    .wgt_addr      (dmvm_wgt_addr),
    .wgt_data      (dmvm_wgt_data),
    .wh            (wh_link.consumer),
    .coef_valid    (coef_valid),
    .coef          (coef)
  );

  coef_store #(.TOTAL_NODES(TOTAL_NODES)) u_coef_store (
    .clk             (clk),
    .rst             (rst),
    .coef_valid      (coef_valid),
    .coef            (coef),
    .feat_bram_addrb (feat_bram_addrb),
    .feat_bram_dout  (feat_bram_dout),
    .gat_ready       (gat_ready)
  );

endmodule

`default_nettype wire

// ==== tb/gat_clk_gen.sv ====
/*
  Clock and reset source for the testbench. rst is high for
  RST_CYCLES rising edges at start-up and again after each rst_req.
*/
`default_nettype none

module gat_clk_gen #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 8
) (
  input  logic rst_req,
  output logic clk,
  output logic rst
);

  int rst_cnt;

  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    rst_cnt = 0;
  end

  always #(PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    if (rst_req) begin
      rst_cnt <= 0;
      rst     <= 1'b1;
    end else if (rst_cnt < RST_CYCLES - 1) begin
      rst_cnt <= rst_cnt + 1;
    end else begin
      rst <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== tb/gat_tb.sv ====
/*
  Testbench for the GAT attention layer. Each case in the cases file
  is loaded into the three memories after a reset, run until gat_ready
  and read back node by node against the expected scores of the file.
*/
`default_nettype none

module gat_tb;
  import gat_pkg::*;

  localparam int NUM_CASES  = 3;
  localparam int H_SLOTS    = 16;
  localparam int DRIVE_DLY  = 1;
  localparam int RST_CYCLES = 8;

  // Word offsets inside one case record
  localparam int OFS_NNZ     = 0;
  localparam int OFS_ROW_LEN = 1;
  localparam int OFS_FIRST   = OFS_ROW_LEN + TOTAL_NODES;
  localparam int OFS_HVAL    = OFS_FIRST + TOTAL_NODES;
  localparam int OFS_HCOL    = OFS_HVAL + H_SLOTS;
  localparam int OFS_WGT     = OFS_HCOL + H_SLOTS;
  localparam int OFS_EXP     = OFS_WGT + WEIGHT_DEPTH * NUM_FEATURE_OUT;
  localparam int REC_WORDS   = OFS_EXP + TOTAL_NODES;

  // Budget per case: load, run, read back, margin
  localparam int LOAD_CYCLES = RST_CYCLES + 4 + H_SLOTS + TOTAL_NODES + WEIGHT_DEPTH + 3;
  localparam int RUN_CYCLES  = H_SLOTS + 4 * TOTAL_NODES;
  localparam int READ_CYCLES = TOTAL_NODES + 1;
  localparam int CYCLE_LIMIT = NUM_CASES * (LOAD_CYCLES + RUN_CYCLES + READ_CYCLES + 64);

  logic                              clk;
  logic                              rst;
  logic                              rst_req;
  logic                              h_data_bram_load_done;
  logic                              h_node_info_bram_load_done;
  logic                              wgt_bram_load_done;
  logic                              h_data_bram_ena;
  logic                              h_data_bram_wea;
  logic [H_DATA_ADDR_W-1:0]          h_data_bram_addra;
  logic [$bits(h_entry_t)-1:0]       h_data_bram_din;
  logic                              h_node_info_bram_ena;
  logic                              h_node_info_bram_wea;
  logic [NODE_INFO_ADDR_W-1:0]       h_node_info_bram_addra;
  logic [$bits(node_info_t)-1:0]     h_node_info_bram_din;
  logic                              wgt_bram_ena;
  logic                              wgt_bram_wea;
  logic [WEIGHT_ADDR_W-1:0]          wgt_bram_addra;
  logic [$bits(wgt_row_t)-1:0]       wgt_bram_din;
  logic [FEAT_ADDR_W-1:0]            feat_bram_addrb;
  logic signed [COEF_WIDTH-1:0]      feat_bram_dout;
  logic                              gat_ready;

  logic [31:0] cases_mem [NUM_CASES * REC_WORDS];
  int          value_errs = 0;
  int          other_errs = 0;
  int          cycle_cnt  = 0;

  gat_clk_gen #(.PERIOD(8), .RST_CYCLES(RST_CYCLES)) u_clk_gen (
    .rst_req (rst_req),
    .clk     (clk),
    .rst     (rst)
  );

  gat_top dut (
    .clk                        (clk),
    .rst                        (rst),
    .h_data_bram_load_done      (h_data_bram_load_done),
    .h_node_info_bram_load_done (h_node_info_bram_load_done),
    .wgt_bram_load_done         (wgt_bram_load_done),
    .h_data_bram_ena            (h_data_bram_ena),
    .h_data_bram_wea            (h_data_bram_wea),
    .h_data_bram_addra          (h_data_bram_addra),
    .h_data_bram_din            (h_data_bram_din),
    .h_node_info_bram_ena       (h_node_info_bram_ena),
    .h_node_info_bram_wea       (h_node_info_bram_wea),
    .h_node_info_bram_addra     (h_node_info_bram_addra),
    .h_node_info_bram_din       (h_node_info_bram_din),
    .wgt_bram_ena               (wgt_bram_ena),
    .wgt_bram_wea               (wgt_bram_wea),
    .wgt_bram_addra             (wgt_bram_addra),
    .wgt_bram_din               (wgt_bram_din),
    .feat_bram_addrb            (feat_bram_addrb),
    .feat_bram_dout             (feat_bram_dout),
    .gat_ready                  (gat_ready)
  );

  // ==========================================================
  // Helpers
  // ==========================================================
  function automatic string case_name(input int c);
    case (c)
      0:       return "positive_sums";
      1:       return "leaky_negative";
      default: return "subgraph_zero_rows";
    endcase
  endfunction

  task automatic report_counts();
    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic check_idle(input int c);
    assert (gat_ready === 1'b0) else begin
      $display("gat_ready was high before the %s run had started", case_name(c));
      other_errs++;
    end
  endtask

  task automatic apply_reset(input int c);
    next_cycle();
    rst_req                    = 1'b1;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    next_cycle();
    rst_req = 1'b0;
    while (rst) begin
      next_cycle();
    end
    check_idle(c);
  endtask

  task automatic load_case(input int c);
    int                          base;
    int                          nnz;
    logic [$bits(wgt_row_t)-1:0] row;
    base = c * REC_WORDS;
    nnz  = int'(cases_mem[base + OFS_NNZ]);
    assert (!$isunknown(cases_mem[base + REC_WORDS - 1]) && nnz <= H_SLOTS) else begin
      $display("The cases file entry for %s is missing or malformed", case_name(c));
      other_errs++;
    end

    for (int i = 0; i < nnz; i++) begin
      next_cycle();
      check_idle(c);
      h_data_bram_ena   = 1'b1;
      h_data_bram_wea   = 1'b1;
      h_data_bram_addra = H_DATA_ADDR_W'(i);
      h_data_bram_din   = {cases_mem[base + OFS_HVAL + i][DATA_WIDTH-1:0],
                           cases_mem[base + OFS_HCOL + i][COL_IDX_WIDTH-1:0]};
    end
    next_cycle();
    h_data_bram_ena = 1'b0;
    h_data_bram_wea = 1'b0;

    for (int n = 0; n < TOTAL_NODES; n++) begin
      next_cycle();
      check_idle(c);
      h_node_info_bram_ena   = 1'b1;
      h_node_info_bram_wea   = 1'b1;
      h_node_info_bram_addra = NODE_INFO_ADDR_W'(n);
      h_node_info_bram_din   = {cases_mem[base + OFS_ROW_LEN + n][ROW_LEN_WIDTH-1:0],
                                cases_mem[base + OFS_FIRST + n][0]};
    end
    next_cycle();
    h_node_info_bram_ena = 1'b0;
    h_node_info_bram_wea = 1'b0;

    // Element 0 sits in the low byte of a weight row
    for (int r = 0; r < WEIGHT_DEPTH; r++) begin
      for (int j = 0; j < NUM_FEATURE_OUT; j++) begin
        row[j*DATA_WIDTH +: DATA_WIDTH] =
          cases_mem[base + OFS_WGT + r * NUM_FEATURE_OUT + j][DATA_WIDTH-1:0];
      end
      next_cycle();
      check_idle(c);
      wgt_bram_ena   = 1'b1;
      wgt_bram_wea   = 1'b1;
      wgt_bram_addra = WEIGHT_ADDR_W'(r);
      wgt_bram_din   = row;
    end
    next_cycle();
    wgt_bram_ena = 1'b0;
    wgt_bram_wea = 1'b0;

    next_cycle();
    check_idle(c);
    h_data_bram_load_done      = 1'b1;
    h_node_info_bram_load_done = 1'b1;
    wgt_bram_load_done         = 1'b1;
  endtask

  task automatic wait_ready();
    while (gat_ready !== 1'b1) begin
      next_cycle();
    end
  endtask

  task automatic check_results(input int c);
    int                    base;
    logic [COEF_WIDTH-1:0] exp_coef;
    base = c * REC_WORDS;
    for (int n = 0; n < TOTAL_NODES; n++) begin
      feat_bram_addrb = FEAT_ADDR_W'(n);
      next_cycle();
      exp_coef = cases_mem[base + OFS_EXP + n];
      assert (feat_bram_dout === exp_coef) else begin
        $display("ERR %s node %0d: expected %0d, actual %0d",
                 case_name(c), n, $signed(exp_coef), feat_bram_dout);
        value_errs++;
      end
    end
  endtask

  // ==========================================================
  // Watchdog
  // ==========================================================
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT) begin
      other_errs++;
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      report_counts();
      $display("test failed");
      $finish;
    end
  end

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    rst_req                    = 1'b0;
    h_data_bram_load_done      = 1'b0;
    h_node_info_bram_load_done = 1'b0;
    wgt_bram_load_done         = 1'b0;
    h_data_bram_ena            = 1'b0;
    h_data_bram_wea            = 1'b0;
    h_data_bram_addra          = '0;
    h_data_bram_din            = '0;
    h_node_info_bram_ena       = 1'b0;
    h_node_info_bram_wea       = 1'b0;
    h_node_info_bram_addra     = '0;
    h_node_info_bram_din       = '0;
    wgt_bram_ena               = 1'b0;
    wgt_bram_wea               = 1'b0;
    wgt_bram_addra             = '0;
    wgt_bram_din               = '0;
    feat_bram_addrb            = '0;

    $readmemh("tb/gat_cases.txt", cases_mem);

    for (int c = 0; c < NUM_CASES; c++) begin
      apply_reset(c);
      load_case(c);
      wait_ready();
      check_results(c);
    end

    report_counts();
    if (value_errs + other_errs == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== gat_top.f ====
logic/gat_pkg.sv
logic/gat_wh_if.sv
logic/gat_bram.sv
logic/spmm_stage.sv
logic/dmvm_stage.sv
logic/coef_store.sv
logic/gat_top.sv
tb/gat_clk_gen.sv
tb/gat_tb.sv

// ==== Bender.yml ====
package:
  name: gat_top

sources:
  - logic/gat_pkg.sv
  - logic/gat_wh_if.sv
  - logic/gat_bram.sv
  - logic/spmm_stage.sv
  - logic/dmvm_stage.sv
  - logic/coef_store.sv
  - logic/gat_top.sv
  - target: test
    files:
      - tb/gat_clk_gen.sv
      - tb/gat_tb.sv

// ==== tb/gat_cases.txt ====
// One record per case: nnz / row_len x12 / first x12 / h value x16 / h col x16 /
// weight rows 0-4, rows 5-9 (w0..w3, rows 8 and 9 are a_src, a_nbr) / expected x12
// positive_sums
10
2 1 2 1 1 1 2 1 1 1 2 1
1 0 0 0 0 0 1 0 0 0 0 0
02 01 03 01 02 04 02 01 01 01 05 01 03 02 01 02
0 4 1 2 7 3 5 6 0 1 2 7 4 3 5 6
01 00 00 00 00 01 00 00 00 00 01 00 00 00 00 01 01 01 00 00
00 01 01 00 00 00 01 01 02 00 00 01 01 02 03 04 01 01 02 01
00000009 00000008 0000000d 00000009 0000000b 00000008
00000005 0000000d 00000006 00000009 00000008 00000009
// leaky_negative
10
2 1 2 1 1 1 2 1 1 1 2 1
1 0 0 0 1 0 0 0 0 0 0 0
02 01 fd 01 02 28 02 01 01 01 05 01 fd 02 01 02
0 4 1 2 7 3 5 6 0 1 2 7 4 3 5 6
01 00 00 00 00 01 00 00 00 00 01 00 00 00 00 01 01 01 00 00
00 01 01 00 00 00 01 01 02 00 00 01 fe 01 00 03 01 fd 02 ff
ffffffff 00000004 ffffffff fffffffa 00000000 00000003
00000000 0000000c 00000003 00000008 ffffffff 00000004
// subgraph_zero_rows
0d
2 1 0 3 1 0 2 0 1 1 2 0
1 0 0 1 0 0 0 1 0 0 1 0
04 02 03 01 02 ff fc 07 01 02 ec 03 fb 00 00 00
0 1 2 3 6 7 5 0 2 4 7 1 3 0 0 0
01 00 00 00 00 01 00 00 00 00 01 00 00 00 00 01 01 01 00 00
00 01 01 00 00 00 01 01 02 00 00 01 01 01 01 01 02 00 ff 01
0000000e 00000003 00000006 ffffffff 00000006 00000002
0000000f 00000000 00000004 fffffff3 ffffffff ffffffff
